/* Makefile */
# Verilator build and run for the RAM board testbench
VERILATOR ?= verilator
TOP       ?= tb_ram_board
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Regression passed

SOURCES := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the testbench printed the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+hdl
hdl/ram_bus_pkg.sv
hdl/sram_pkg.sv
hdl/bank_control.sv
hdl/am9150_sram.sv
hdl/read_return.sv
hdl/ram_board.sv
test/tb_ram_board.sv

/* hdl/am9150_sram.sv */
/* Clocked model of one 1024x4 Am9150; no tri-state, a chip not being read
   gives zero so banks can be ORed. No reset pin, contents undefined at start */
`timescale 1ns/1ps
`include "ram_defines.svh"

module am9150_sram (
    input  logic                  clk,
    input  sram_pkg::chip_addr_t  address,
    input  sram_pkg::nibble_t     data_in,
    input  logic                  write_enable_n,    // Active low
    input  logic                  chip_select_n,     // Active low
    input  logic                  output_enable_n,   // Active low
    output sram_pkg::nibble_t     data_out           // Registered
);

    sram_pkg::nibble_t mem [0:`RAM_CHIP_DEPTH-1];    // Maps to block RAM

    logic rd_en;
    logic wr_en;

    assign wr_en = !chip_select_n && !write_enable_n;
    // Write has priority, outputs stay quiet during it
    assign rd_en = !chip_select_n && !output_enable_n && write_enable_n;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[address] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            data_out <= mem[address];
        end else begin
            data_out <= '0;       // Stands in for high impedance
        end
    end

    // Select from the control stage must come with a clean address
    a_addr_known: assert property (@(posedge clk)
        !chip_select_n |-> !$isunknown(address));

endmodule

/* hdl/bank_control.sv */
/* Request stage; one request per edge, dropped while a clear sweep runs.
   clear_req wins over a request sampled at the same edge */
`timescale 1ns/1ps
`include "ram_defines.svh"

module bank_control (
    input  logic                   clk,
    input  logic                   RESET_n,
    input  ram_bus_pkg::bus_req_t  req,
    input  logic                   clear_req,
    output sram_pkg::chip_ctrl_t   ctrl,
    output logic                   rd_pend,     // Read issued with this ctrl word
    output logic                   busy         // Clear sweep running
);

    typedef enum logic {
        st_idle,
        st_clearing
    } state_t;

    // All chips deselected, outputs quiet
    localparam sram_pkg::chip_ctrl_t ctrl_off = '{
        address:         '0,
        data_in:         '0,
        write_enable_n:  1'b1,
        output_enable_n: 1'b1,
        chip_select_n:   '1
    };

    state_t                state;
    sram_pkg::chip_addr_t  sweep_cnt;    // Next address to clear, rests at 0 in idle
    sram_pkg::bank_t       bank;
    sram_pkg::chip_ctrl_t  req_ctrl;     // Decoded CPU request
    sram_pkg::chip_ctrl_t  clr_ctrl;     // Sweep write word

    assign bank = req.addr[`RAM_ADDR_W-1];   // Top bit picks the chip pair

    // CPU request decode
    always_comb begin
        req_ctrl                 = ctrl_off;
        req_ctrl.address         = req.addr[`RAM_CHIP_ADDR_W-1:0];
        req_ctrl.data_in         = req.wdata;
        req_ctrl.write_enable_n  = ~req.wr;
        req_ctrl.output_enable_n = ~req.rd;
        for (int b = 0; b < `RAM_BANKS; b++) begin
            // Only the addressed pair sees a select
            req_ctrl.chip_select_n[b] = ~((req.rd | req.wr) && (bank == sram_pkg::bank_t'(b)));
        end
    end

    // Both banks written with zero at the sweep address
    always_comb begin
        clr_ctrl                 = ctrl_off;
        clr_ctrl.address         = sweep_cnt;
        clr_ctrl.write_enable_n  = 1'b0;
        clr_ctrl.chip_select_n   = '0;
    end

    always_ff @(posedge clk) begin
        if (!RESET_n) begin
            state     <= st_idle;
            sweep_cnt <= '0;
            ctrl      <= ctrl_off;
            rd_pend   <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (clear_req) begin
                        state     <= st_clearing;
                        ctrl      <= clr_ctrl;          // Address 0 goes out first
                        sweep_cnt <= sweep_cnt + 1'b1;
                        rd_pend   <= 1'b0;              // A read here is lost
                    end else begin
                        ctrl      <= req_ctrl;
                        rd_pend   <= req.rd;
                    end
                end
                st_clearing: begin
                    rd_pend <= 1'b0;                    // Requests dropped
                    if (sweep_cnt == '0) begin
                        // Counter wrapped, last word already issued
                        state <= st_idle;
                        ctrl  <= ctrl_off;
                    end else begin
                        ctrl      <= clr_ctrl;
                        sweep_cnt <= sweep_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                    ctrl  <= ctrl_off;
                end
            endcase
        end
    end

    assign busy = (state == st_clearing);

    // CPU must not strobe both directions
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!RESET_n)
        !(req.rd && req.wr));

    // Every cycle of the sweep hits both banks
    a_clear_selects: assert property (@(posedge clk) disable iff (!RESET_n)
        (state == st_clearing) |-> (ctrl.chip_select_n == '0 && !ctrl.write_enable_n));

endmodule

/* hdl/ram_board.sv */
/* 2 KB board top, four Am9150-style chips; memory undefined until a clear
   finishes, requests during busy are dropped without any handshake */
`timescale 1ns/1ps

module ram_board (
    input  logic                clk,
    input  logic                RESET_n,
    input  logic                rd,
    input  logic                wr,
    input  ram_bus_pkg::addr_t  addr,
    input  ram_bus_pkg::byte_t  wdata,
    input  logic                clear_req,
    output ram_bus_pkg::byte_t  rdata,
    output logic                rd_valid,
    output logic                busy
);

    ram_bus_pkg::bus_req_t  req;
    sram_pkg::chip_ctrl_t   ctrl;       // Shared by all four chips
    logic                   rd_pend;

    sram_pkg::nibble_t      b0_lo_q;
    sram_pkg::nibble_t      b0_hi_q;
    sram_pkg::nibble_t      b1_lo_q;
    sram_pkg::nibble_t      b1_hi_q;
    ram_bus_pkg::byte_t     bank0_data;
    ram_bus_pkg::byte_t     bank1_data;

    assign req = '{rd: rd, wr: wr, addr: addr, wdata: wdata};

    bank_control u_ctrl (
        .clk       (clk),
        .RESET_n   (RESET_n),
        .req       (req),
        .clear_req (clear_req),
        .ctrl      (ctrl),
        .rd_pend   (rd_pend),
        .busy      (busy)
    );

    // Bank 0, lower 1 KB
    am9150_sram u_b0_lo (
        .clk (clk), .address (ctrl.address), .data_in (ctrl.data_in[3:0]),
        .write_enable_n (ctrl.write_enable_n), .chip_select_n (ctrl.chip_select_n[0]),
        .output_enable_n (ctrl.output_enable_n), .data_out (b0_lo_q)
    );
    am9150_sram u_b0_hi (
        .clk (clk), .address (ctrl.address), .data_in (ctrl.data_in[7:4]),
        .write_enable_n (ctrl.write_enable_n), .chip_select_n (ctrl.chip_select_n[0]),
        .output_enable_n (ctrl.output_enable_n), .data_out (b0_hi_q)
    );

    // Bank 1, upper 1 KB
    am9150_sram u_b1_lo (
        .clk (clk), .address (ctrl.address), .data_in (ctrl.data_in[3:0]),
        .write_enable_n (ctrl.write_enable_n), .chip_select_n (ctrl.chip_select_n[1]),
        .output_enable_n (ctrl.output_enable_n), .data_out (b1_lo_q)
    );
    am9150_sram u_b1_hi (
        .clk (clk), .address (ctrl.address), .data_in (ctrl.data_in[7:4]),
        .write_enable_n (ctrl.write_enable_n), .chip_select_n (ctrl.chip_select_n[1]),
        .output_enable_n (ctrl.output_enable_n), .data_out (b1_hi_q)
    );

    assign bank0_data = {b0_hi_q, b0_lo_q};   // Pair forms one byte
    assign bank1_data = {b1_hi_q, b1_lo_q};

    read_return u_ret (
        .clk        (clk),
        .RESET_n    (RESET_n),
        .bank0_data (bank0_data),
        .bank1_data (bank1_data),
        .rd_pend    (rd_pend),
        .rdata      (rdata),
        .rd_valid   (rd_valid)
    );

endmodule

/* hdl/ram_bus_pkg.sv */
/* CPU-side bus types; rd and wr are levels sampled every rising edge,
   never both high */
`include "ram_defines.svh"

package ram_bus_pkg;

    // Byte address over both banks
    typedef logic [`RAM_ADDR_W-1:0] addr_t;

    typedef logic [7:0] byte_t;          // CPU data

    // One request per clock edge
    typedef struct packed {
        logic  rd;                        // Read strobe, level
        logic  wr;                        // Write strobe, level
        addr_t addr;
        byte_t wdata;                     // Ignored unless wr
    } bus_req_t;                          // 21 bits

endpackage

/* hdl/ram_defines.svh */
/* Board sizes for the 2 KB static RAM board, four 1024x4 chips in two banks.
   Chip and CPU address widths must stay one bit apart, the top bit picks the bank */
`ifndef RAM_DEFINES_SVH
`define RAM_DEFINES_SVH

// CPU side
`define RAM_ADDR_W      11   // 2048 bytes

// One Am9150-style chip
`define RAM_CHIP_ADDR_W 10
`define RAM_CHIP_DEPTH  1024 // Words of 4 bits

// Chip pairs on the board
`define RAM_BANKS       2    // Bank index is addr[RAM_ADDR_W-1]

`endif

/* hdl/read_return.sv */
/* Return stage; rdata holds the last read byte, rd_valid is a one-cycle
   pulse two edges after the chips were driven */
`timescale 1ns/1ps

module read_return (
    input  logic                clk,
    input  logic                RESET_n,
    input  ram_bus_pkg::byte_t  bank0_data,   // Zero unless bank 0 read
    input  ram_bus_pkg::byte_t  bank1_data,   // Zero unless bank 1 read
    input  logic                rd_pend,      // From control stage
    output ram_bus_pkg::byte_t  rdata,
    output logic                rd_valid
);

    logic rd_pend_q;      // Lines up with chip data_out

    always_ff @(posedge clk) begin
        if (!RESET_n) begin
            rd_pend_q <= 1'b0;
            rd_valid  <= 1'b0;
            rdata     <= '0;
        end else begin
            rd_pend_q <= rd_pend;
            rd_valid  <= rd_pend_q;
            if (rd_pend_q) begin
                rdata <= bank0_data | bank1_data;   // Wired-OR bus, one bank active
            end
        end
    end

    // Quiet chips on every non-read cycle, else the OR would corrupt data
    a_idle_zero: assert property (@(posedge clk) disable iff (!RESET_n)
        !rd_pend_q |-> (bank0_data == '0 && bank1_data == '0));

endmodule

/* hdl/sram_pkg.sv */
/* Chip-side types; all strobes are active low like the Am9150 pins,
   data_in carries both nibbles of a chip pair */
`include "ram_defines.svh"

package sram_pkg;

    typedef logic [`RAM_CHIP_ADDR_W-1:0] chip_addr_t; // Word inside one chip

    typedef logic [3:0] nibble_t;        // Chip data width

    // Taken from the top CPU address bit
    typedef logic bank_t;

    // Control word shared by all four chips
    typedef struct packed {
        chip_addr_t              address;
        ram_bus_pkg::byte_t      data_in;         // High nibble to hi chip, low to lo chip
        logic                    write_enable_n;
        logic                    output_enable_n;
        logic [`RAM_BANKS-1:0]   chip_select_n;   // One select per bank
    } chip_ctrl_t;                                // 22 bits

endpackage

/* test/tb_ram_board.sv */
/* Random testbench for the RAM board; the model is a byte array plus a queue of
   expected reads. Memory is only trusted after the first clear */
`timescale 1ns/1ps
`include "ram_defines.svh"

module tb_ram_board;

    localparam int MEM_BYTES    = 1 << `RAM_ADDR_W;
    localparam int CLEAR_CYCLES = 1100;              // Per clear with slack
    localparam int NUM_CLEARS   = 2;
    localparam int REQ_CYCLES   = 64 + 2000 + 32 + 100 + 64;
    localparam int TIMEOUT_CYC  = (REQ_CYCLES + CLEAR_CYCLES * NUM_CLEARS) * 2;

    logic                clk;
    logic                RESET_n;
    logic                rd;
    logic                wr;
    ram_bus_pkg::addr_t  addr;
    ram_bus_pkg::byte_t  wdata;
    logic                clear_req;
    ram_bus_pkg::byte_t  rdata;
    logic                rd_valid;
    logic                busy;

    ram_bus_pkg::byte_t  model_mem [MEM_BYTES];     // Reference memory
    ram_bus_pkg::byte_t  exp_q [$];                 // Reads in flight in issue order
    ram_bus_pkg::byte_t  last_rdata;                // rdata must hold this
    ram_bus_pkg::byte_t  exp_b;
    string               test_name;
    int                  valid_run;                 // Consecutive rd_valid cycles
    int                  max_run;

    ram_board dut0 (
        .clk       (clk),
        .RESET_n   (RESET_n),
        .rd        (rd),
        .wr        (wr),
        .addr      (addr),
        .wdata     (wdata),
        .clear_req (clear_req),
        .rdata     (rdata),
        .rd_valid  (rd_valid),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_byte(input string name, input ram_bus_pkg::byte_t expected,
                              input ram_bus_pkg::byte_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected 0x%h, actual 0x%h", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "Byte mismatch");
        end
    endtask

    task automatic check_flag(input string name, input bit expected, input bit actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0b, actual %0b", name, expected, actual);
            $display("Regression failed");
            $fatal(1, "Flag mismatch");
        end
    endtask

    // One cycle of CPU drive; model follows only what the board accepts
    task automatic issue(input logic r, input logic w, input ram_bus_pkg::addr_t a,
                         input ram_bus_pkg::byte_t d, input logic clr);
        rd        = r;
        wr        = w;
        addr      = a;
        wdata     = d;
        clear_req = clr;
        if (!busy) begin                            // busy high means dropped
            if (clr) begin
                for (int i = 0; i < MEM_BYTES; i++) begin
                    model_mem[i] = '0;
                end
            end else if (w) begin
                model_mem[a] = d;
            end else if (r) begin
                exp_q.push_back(model_mem[a]);      // Value at issue time
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycle();
        issue(1'b0, 1'b0, '0, '0, 1'b0);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) idle_cycle();
    endtask

    function automatic ram_bus_pkg::addr_t rand_addr();
        return ram_bus_pkg::addr_t'($urandom_range(0, MEM_BYTES - 1));
    endfunction

    // Word offset inside one bank
    function automatic sram_pkg::chip_addr_t rand_chip_addr();
        return sram_pkg::chip_addr_t'($urandom_range(0, `RAM_CHIP_DEPTH - 1));
    endfunction

    function automatic ram_bus_pkg::byte_t rand_byte();
        return ram_bus_pkg::byte_t'($urandom_range(0, 255));
    endfunction

    // Clear, check busy rises, wait for the sweep to end
    task automatic run_clear();
        issue(1'b0, 1'b0, '0, '0, 1'b1);
        check_flag({test_name, " busy rise"}, 1'b1, busy);
        while (busy) begin
            // Traffic and clear pulses during the sweep are all dropped
            case ($urandom_range(0, 3))
                0: issue(1'b1, 1'b0, rand_addr(), '0, 1'b0);
                1: issue(1'b0, 1'b1, rand_addr(), rand_byte(), 1'b0);
                2: issue(1'b0, 1'b0, '0, '0, 1'b1);
                default: idle_cycle();
            endcase
        end
        idle_cycle();
        check_flag({test_name, " busy stays low"}, 1'b0, busy);
    endtask

    task automatic read_random(input int count);
        for (int i = 0; i < count; i++) begin
            issue(1'b1, 1'b0, rand_addr(), '0, 1'b0);
        end
        wait_drain();
    endtask

    // Return checker samples mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (RESET_n) begin
            if (rd_valid) begin
                if (exp_q.size() == 0) begin
                    report_error("rd_valid seen with no read outstanding");
                end else begin
                    exp_b = exp_q.pop_front();
                    check_byte(test_name, exp_b, rdata);
                    last_rdata = rdata;
                    valid_run++;
                    if (valid_run > max_run) max_run = valid_run;
                end
            end else begin
                check_byte({test_name, " rdata hold"}, last_rdata, rdata);
                valid_run = 0;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("Simulation timed out after %0d cycles", TIMEOUT_CYC);
        $display("Regression failed");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        ram_bus_pkg::addr_t burst_a [16];
        void'($urandom(32'h48dd));
        rd         = 1'b0;
        wr         = 1'b0;
        addr       = '0;
        wdata      = '0;
        clear_req  = 1'b0;
        RESET_n    = 1'b0;
        last_rdata = '0;
        valid_run  = 0;
        max_run    = 0;
        test_name  = "reset";
        repeat (2) @(posedge clk);
        #1;
        RESET_n = 1'b1;
        idle_cycle();

        test_name = "clear";
        run_clear();
        read_random(64);                            // Model is all zero here

        test_name = "random traffic";
        for (int i = 0; i < 2000; i++) begin
            case ($urandom_range(0, 2))
                0: issue(1'b1, 1'b0, rand_addr(), '0, 1'b0);
                1: issue(1'b0, 1'b1, rand_addr(), rand_byte(), 1'b0);
                default: idle_cycle();
            endcase
        end
        wait_drain();

        test_name = "back-to-back";
        for (int i = 0; i < 8; i++) begin
            burst_a[2*i]   = {1'b0, rand_chip_addr()};   // Bank 0
            burst_a[2*i+1] = {1'b1, rand_chip_addr()};   // Bank 1
        end
        for (int i = 0; i < 16; i++) begin
            issue(1'b0, 1'b1, burst_a[i], rand_byte(), 1'b0);
        end
        max_run = 0;
        for (int i = 0; i < 16; i++) begin
            issue(1'b1, 1'b0, burst_a[i], '0, 1'b0);                      // Banks alternate
        end
        wait_drain();
        idle_cycle();
        if (max_run < 16) report_error("Back-to-back reads did not return one per cycle");

        test_name = "write then read";
        for (int i = 0; i < 50; i++) begin
            addr = rand_addr();
            issue(1'b0, 1'b1, addr, rand_byte(), 1'b0);
            issue(1'b1, 1'b0, addr, '0, 1'b0);
        end
        wait_drain();

        test_name = "clear after traffic";
        run_clear();
        read_random(64);
        repeat (4) idle_cycle();

        if (exp_q.size() != 0) begin
            $display("%0d reads were never answered", exp_q.size());
            $display("Regression failed");
            $fatal(1, "Unanswered reads");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule
